// File: he_macros.svh
`ifndef HE_MACROS_SVH
`define HE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// physical address and data word
`define HE_ADDR_W      40
`define HE_DATA_W      64

// coefficient width and largest supported polynomial degree exponent
`define HE_COEF_W      30
`define HE_LOGN_MAX    12

// one bank holds half the slots, so its address is one bit short
`define HE_SLOT_W      11

// csr index and the io field on top of the address
`define HE_CSR_IDX_W   8
`define HE_HIO_W       4

//////////////////////////////////////////////////////////////////////
// csr map
//////////////////////////////////////////////////////////////////////

`define HE_CSR_LOGN    0
`define HE_CSR_A1      1
`define HE_CSR_WB1     2
`define HE_CSR_A2      3
`define HE_CSR_WB2     4
`define HE_CSR_START   5
`define HE_CSR_STATUS  6

// interrupt target for the completion write
`define HE_INTR_ADDR   40'h30_0000

`endif

// File: he_pkg.sv
`default_nettype none

`include "he_macros.svh"

package he_pkg;

   typedef enum logic {
      HE_MSG_RD = 1'b0,
      HE_MSG_WR = 1'b1
   } he_msg_e;

   // wide enough to hold HE_LOGN_MAX itself
   typedef logic [$clog2(`HE_LOGN_MAX+1)-1:0] he_logn_t;

   typedef struct packed {
      he_msg_e               msg;
      logic [`HE_ADDR_W-1:0] addr;
      logic [`HE_DATA_W-1:0] data;
   } he_host_cmd_s;

   typedef struct packed {
      he_msg_e               msg;
      logic [`HE_ADDR_W-1:0] addr;
      logic [`HE_DATA_W-1:0] data;
   } he_host_resp_s;

   // one address word, seen either as device space or as a csr index
   typedef union packed {
      struct packed {
         logic [`HE_HIO_W-1:0]            hio;
         logic [`HE_ADDR_W-`HE_HIO_W-1:0] offset;
      } global_v;
      struct packed {
         logic [`HE_ADDR_W-`HE_CSR_IDX_W-1:0] pad;
         logic [`HE_CSR_IDX_W-1:0]            idx;
      } local_v;
   } he_addr_u;

   typedef struct packed {
      he_msg_e               msg;
      logic [`HE_ADDR_W-1:0] addr;
      logic [`HE_DATA_W-1:0] data;
   } he_mem_cmd_s;

   typedef struct packed {
      he_logn_t    logn;
      logic [31:0] a1;
      logic [31:0] wb1;
      logic [31:0] a2;
      logic [31:0] wb2;
   } he_job_cfg_s;

   typedef struct packed {
      logic [`HE_ADDR_W-1:0] base;
      he_logn_t              logn;
      logic                  store;
   } he_dma_req_s;

endpackage

`default_nettype wire

// File: he_csr_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "he_macros.svh"

module he_csr_regs (
   input  wire logic                  clk_i,
   input  wire logic                  reset_i,
   input  wire logic                  host_cmd_v_i,
   input  wire he_pkg::he_host_cmd_s  host_cmd_i,
   input  wire logic                  busy_i,
   output logic                       host_resp_v_o,
   output he_pkg::he_host_resp_s      host_resp_o,
   output he_pkg::he_job_cfg_s        cfg_o,
   output logic                       start_o
);

   he_pkg::he_addr_u      cmd_addr;
   he_pkg::he_job_cfg_s   cfg_r;
   he_pkg::he_host_resp_s resp_r;
   logic                  resp_v_r;
   logic                  start_r;
   logic                  is_wr;
   logic                  csr_hit;
   logic [`HE_DATA_W-1:0] rd_val;

   assign cmd_addr = host_cmd_i.addr;
   assign is_wr    = (host_cmd_i.msg == he_pkg::HE_MSG_WR);

   // only hio zero lands in the register file
   assign csr_hit  = (cmd_addr.global_v.hio == '0);

   //////////////////////////////////////////////////////////////////////
   // read mux
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      rd_val = '0;
      case (cmd_addr.local_v.idx)
         `HE_CSR_LOGN:   rd_val = `HE_DATA_W'(cfg_r.logn);
         `HE_CSR_A1:     rd_val = `HE_DATA_W'(cfg_r.a1);
         `HE_CSR_WB1:    rd_val = `HE_DATA_W'(cfg_r.wb1);
         `HE_CSR_A2:     rd_val = `HE_DATA_W'(cfg_r.a2);
         `HE_CSR_WB2:    rd_val = `HE_DATA_W'(cfg_r.wb2);
         `HE_CSR_START:  rd_val = `HE_DATA_W'(start_r);
         // a pending start already counts as busy
         `HE_CSR_STATUS: rd_val = `HE_DATA_W'(busy_i | start_r);
         default:        rd_val = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // register writes and response valid
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         resp_v_r <= 1'b0;
         start_r  <= 1'b0;
         cfg_r    <= '0;
      end
      else
      begin
         // reads outside the csr space are dropped silently
         resp_v_r <= host_cmd_v_i & (csr_hit | is_wr);
         start_r  <= 1'b0;
         if (host_cmd_v_i && csr_hit && is_wr)
         begin
            case (cmd_addr.local_v.idx)
               `HE_CSR_LOGN:  cfg_r.logn <= host_cmd_i.data[$bits(he_pkg::he_logn_t)-1:0];
               `HE_CSR_A1:    cfg_r.a1   <= host_cmd_i.data[31:0];
               `HE_CSR_WB1:   cfg_r.wb1  <= host_cmd_i.data[31:0];
               `HE_CSR_A2:    cfg_r.a2   <= host_cmd_i.data[31:0];
               `HE_CSR_WB2:   cfg_r.wb2  <= host_cmd_i.data[31:0];
               `HE_CSR_START: start_r    <= host_cmd_i.data[0];
               default:       ;
            endcase
         end
      end
   end

   // response fields follow every command, writes echo their data
   always_ff @(posedge clk_i)
   begin
      if (host_cmd_v_i)
      begin
         resp_r.msg  <= host_cmd_i.msg;
         resp_r.addr <= host_cmd_i.addr;
         resp_r.data <= is_wr ? host_cmd_i.data : rd_val;
      end
   end

   assign host_resp_v_o = resp_v_r;
   assign host_resp_o   = resp_r;
   assign cfg_o         = cfg_r;
   assign start_o       = start_r;

endmodule

`default_nettype wire

// File: he_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "he_macros.svh"

module he_sequencer (
   input  wire logic                 clk_i,
   input  wire logic                 reset_i,
   input  wire logic                 start_i,
   input  wire he_pkg::he_job_cfg_s  cfg_i,
   input  wire logic                 dma_done_i,
   input  wire logic                 mem_resp_v_i,
   output logic                      dma_start_o,
   output he_pkg::he_dma_req_s       dma_req_o,
   output logic                      load_phase_o,
   output logic                      intr_set_o,
   output logic                      intr_clr_o,
   output logic                      busy_o
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOAD,
      ST_WB,
      ST_NEXT,
      ST_INTR,
      ST_WAIT_CLR
   } state_e;

   state_e      state_r;
   state_e      state_n;
   logic        round_r;
   logic [31:0] ptr;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= ST_IDLE;
         round_r <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         // pair 2 follows pair 1, then back to pair 1 for the next job
         if (state_r == ST_WB && dma_done_i)
            round_r <= ~round_r;
      end
   end

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         ST_IDLE:     if (start_i) state_n = ST_LOAD;
         ST_LOAD:     if (dma_done_i) state_n = ST_WB;
         ST_WB:       if (dma_done_i) state_n = ST_NEXT;
         // round already toggled here, so 1 means pair 2 is still to do
         ST_NEXT:     state_n = round_r ? ST_LOAD : ST_INTR;
         ST_INTR:     state_n = ST_WAIT_CLR;
         ST_WAIT_CLR: if (mem_resp_v_i) state_n = ST_IDLE;
         default:     state_n = ST_IDLE;
      endcase
   end

   // pointer for the current phase of the current round
   always_comb
   begin
      if (state_r == ST_WB)
         ptr = round_r ? cfg_i.wb2 : cfg_i.wb1;
      else
         ptr = round_r ? cfg_i.a2 : cfg_i.a1;
   end

   assign dma_req_o = '{base  : `HE_ADDR_W'(ptr),
                        logn  : cfg_i.logn,
                        store : (state_r == ST_WB)};

   assign dma_start_o  = (state_r == ST_LOAD) || (state_r == ST_WB);
   assign load_phase_o = (state_r == ST_LOAD);
   assign intr_set_o   = (state_r == ST_INTR);
   // the set write is answered, clear right away
   assign intr_clr_o   = (state_r == ST_WAIT_CLR) && mem_resp_v_i;
   assign busy_o       = (state_r != ST_IDLE);

endmodule

`default_nettype wire

// File: he_mem_master.sv
`timescale 1ns/1ns
`default_nettype none

`include "he_macros.svh"

module he_mem_master (
   input  wire logic                    clk_i,
   input  wire logic                    reset_i,
   input  wire logic                    dma_start_i,
   input  wire he_pkg::he_dma_req_s     dma_req_i,
   input  wire logic                    intr_set_i,
   input  wire logic                    intr_clr_i,
   input  wire logic                    mem_resp_v_i,
   input  wire logic [`HE_COEF_W-1:0]   rd_data_i,
   output logic                         mem_cmd_v_o,
   output he_pkg::he_mem_cmd_s          mem_cmd_o,
   output logic                         dma_done_o,
   output logic                         wr_v_o,
   output logic                         rd_v_o,
   output logic [`HE_LOGN_MAX-1:0]      count_o
);

   typedef enum logic [1:0] {
      DMA_IDLE,
      DMA_FETCH,
      DMA_WAIT,
      DMA_DONE
   } dma_state_e;

   dma_state_e          state_r;
   dma_state_e          state_n;
   // one extra bit so a full 2^HE_LOGN_MAX transfer can be counted
   logic [`HE_LOGN_MAX:0] cnt_r;
   logic [`HE_LOGN_MAX:0] len;
   logic                  cnt_end;
   logic                  resp_in_wait;
   logic                  dma_cmd_v;
   logic                  intr_v;
   he_pkg::he_mem_cmd_s   dma_cmd;
   he_pkg::he_mem_cmd_s   intr_cmd;

   assign len          = {{`HE_LOGN_MAX{1'b0}}, 1'b1} << dma_req_i.logn;
   assign cnt_end      = (cnt_r == len);
   assign resp_in_wait = (state_r == DMA_WAIT) && mem_resp_v_i;

   //////////////////////////////////////////////////////////////////////
   // fetch / wait loop
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= DMA_IDLE;
         cnt_r   <= '0;
      end
      else
      begin
         state_r <= state_n;
         if (state_r == DMA_IDLE || state_r == DMA_DONE)
            cnt_r <= '0;
         else if (resp_in_wait)
            cnt_r <= cnt_r + 1'b1;
      end
   end

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         DMA_IDLE:  if (dma_start_i) state_n = DMA_FETCH;
         DMA_FETCH: state_n = cnt_end ? DMA_DONE : DMA_WAIT;
         DMA_WAIT:  if (mem_resp_v_i) state_n = DMA_FETCH;
         default:   state_n = DMA_IDLE;
      endcase
   end

   // one outstanding command at a time
   assign dma_cmd_v = (state_r == DMA_FETCH) && !cnt_end;
   assign dma_cmd   = '{msg  : dma_req_i.store ? he_pkg::HE_MSG_WR : he_pkg::HE_MSG_RD,
                        addr : dma_req_i.base + (`HE_ADDR_W'(cnt_r) << 2),
                        data : `HE_DATA_W'(rd_data_i)};

   // all ones raises the interrupt, zero drops it
   assign intr_v   = intr_set_i | intr_clr_i;
   assign intr_cmd = '{msg  : he_pkg::HE_MSG_WR,
                       addr : `HE_INTR_ADDR,
                       data : {`HE_DATA_W{intr_set_i}}};

   assign mem_cmd_v_o = intr_v | dma_cmd_v;
   assign mem_cmd_o   = intr_v ? intr_cmd : dma_cmd;

   //////////////////////////////////////////////////////////////////////
   // bank side strobes
   //////////////////////////////////////////////////////////////////////

   assign dma_done_o = (state_r == DMA_DONE);
   assign wr_v_o     = resp_in_wait && !dma_req_i.store;
   // prefetch next store word so it is ready in the following fetch cycle
   assign rd_v_o     = dma_req_i.store &&
                       (((state_r == DMA_IDLE) && dma_start_i) || resp_in_wait);
   assign count_o    = cnt_r[`HE_LOGN_MAX-1:0];

endmodule

`default_nettype wire

// File: he_coef_banks.sv
`timescale 1ns/1ns
`default_nettype none

`include "he_macros.svh"

module he_coef_banks (
   input  wire logic                    clk_i,
   input  wire logic                    load_phase_i,
   input  wire he_pkg::he_logn_t        logn_i,
   input  wire logic                    wr_v_i,
   input  wire logic                    rd_v_i,
   input  wire logic [`HE_LOGN_MAX-1:0] count_i,
   input  wire logic [`HE_DATA_W-1:0]   mem_resp_data_i,
   output logic [`HE_COEF_W-1:0]        rd_data_o
);

   localparam int unsigned DEPTH = 1 << `HE_SLOT_W;

   logic [`HE_LOGN_MAX-1:0] cnt_rev;
   logic [`HE_LOGN_MAX-1:0] wr_slot;
   logic [`HE_LOGN_MAX-1:0] rd_slot;
   logic                    first_rd_r;
   logic                    rd_bank_r;

   // reverse over the full width, then drop the unused low bits
   assign cnt_rev = {<<{count_i}};
   assign wr_slot = cnt_rev >> (`HE_LOGN_MAX - logn_i);

   // first store read uses count as is, later reads run one ahead
   assign rd_slot = first_rd_r ? count_i : count_i + 1'b1;

   always_ff @(posedge clk_i)
   begin
      if (load_phase_i)
         first_rd_r <= 1'b1;
      else if (rd_v_i)
         first_rd_r <= 1'b0;
      if (rd_v_i)
         rd_bank_r <= rd_slot[0];
   end

   //////////////////////////////////////////////////////////////////////
   // even and odd slot banks
   //////////////////////////////////////////////////////////////////////

   for (genvar g = 0; g < 2; g++)
   begin : gen_bank
      logic [`HE_COEF_W-1:0] mem [DEPTH];
      logic [`HE_COEF_W-1:0] rd_q;

      always_ff @(posedge clk_i)
      begin
         if (load_phase_i && wr_v_i && (wr_slot[0] == 1'(g)))
            mem[wr_slot[`HE_SLOT_W:1]] <= mem_resp_data_i[`HE_COEF_W-1:0];
         if (rd_v_i && (rd_slot[0] == 1'(g)))
            rd_q <= mem[rd_slot[`HE_SLOT_W:1]];
      end
   end

   assign rd_data_o = rd_bank_r ? gen_bank[1].rd_q : gen_bank[0].rd_q;

endmodule

`default_nettype wire

// File: he_accel_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "he_macros.svh"

module he_accel_top (
   input  wire logic                  clk_i,
   input  wire logic                  reset_i,
   input  wire logic                  host_cmd_v_i,
   input  wire he_pkg::he_host_cmd_s  host_cmd_i,
   output logic                       host_resp_v_o,
   output he_pkg::he_host_resp_s      host_resp_o,
   output logic                       mem_cmd_v_o,
   output he_pkg::he_mem_cmd_s        mem_cmd_o,
   input  wire logic                  mem_resp_v_i,
   input  wire logic [`HE_DATA_W-1:0] mem_resp_data_i
);

   he_pkg::he_job_cfg_s     cfg;
   he_pkg::he_dma_req_s     dma_req;
   logic                    start;
   logic                    busy;
   logic                    dma_start;
   logic                    dma_done;
   logic                    intr_set;
   logic                    intr_clr;
   logic                    load_phase;
   logic                    wr_v;
   logic                    rd_v;
   logic [`HE_LOGN_MAX-1:0] count;
   logic [`HE_COEF_W-1:0]   rd_data;

   //////////////////////////////////////////////////////////////////////
   // host side
   //////////////////////////////////////////////////////////////////////

   he_csr_regs csr_i (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .host_cmd_v_i  (host_cmd_v_i),
      .host_cmd_i    (host_cmd_i),
      .busy_i        (busy),
      .host_resp_v_o (host_resp_v_o),
      .host_resp_o   (host_resp_o),
      .cfg_o         (cfg),
      .start_o       (start)
   );

   //////////////////////////////////////////////////////////////////////
   // job control and coefficient storage
   //////////////////////////////////////////////////////////////////////

   he_sequencer seq_i (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (start),
      .cfg_i        (cfg),
      .dma_done_i   (dma_done),
      .mem_resp_v_i (mem_resp_v_i),
      .dma_start_o  (dma_start),
      .dma_req_o    (dma_req),
      .load_phase_o (load_phase),
      .intr_set_o   (intr_set),
      .intr_clr_o   (intr_clr),
      .busy_o       (busy)
   );

   he_coef_banks banks_i (
      .clk_i           (clk_i),
      .load_phase_i    (load_phase),
      .logn_i          (dma_req.logn),
      .wr_v_i          (wr_v),
      .rd_v_i          (rd_v),
      .count_i         (count),
      .mem_resp_data_i (mem_resp_data_i),
      .rd_data_o       (rd_data)
   );

   //////////////////////////////////////////////////////////////////////
   // memory side
   //////////////////////////////////////////////////////////////////////

   he_mem_master mem_i (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .dma_start_i  (dma_start),
      .dma_req_i    (dma_req),
      .intr_set_i   (intr_set),
      .intr_clr_i   (intr_clr),
      .mem_resp_v_i (mem_resp_v_i),
      .rd_data_i    (rd_data),
      .mem_cmd_v_o  (mem_cmd_v_o),
      .mem_cmd_o    (mem_cmd_o),
      .dma_done_o   (dma_done),
      .wr_v_o       (wr_v),
      .rd_v_o       (rd_v),
      .count_o      (count)
   );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 4
) (
   output logic clk_o,
   output logic reset_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // released on a falling edge, away from the sampling edge
   initial
   begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;
   end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "he_macros.svh"

module tb_checker #(
   parameter logic [31:0] SEED = 32'h6d9c_6f57
) (
   input wire logic                  clk_i,
   input wire logic                  reset_i,
   input wire logic                  host_cmd_v_i,
   input wire he_pkg::he_host_cmd_s  host_cmd_i,
   input wire logic                  host_resp_v_i,
   input wire he_pkg::he_host_resp_s host_resp_i,
   input wire logic                  mem_cmd_v_i,
   input wire he_pkg::he_mem_cmd_s   mem_cmd_i
);

   localparam int unsigned KIND_RD   = 0;
   localparam int unsigned KIND_WR   = 1;
   localparam int unsigned KIND_LAST = 2;

   int unsigned err_cnt    = 0;
   int unsigned csr_checks = 0;
   int unsigned mem_checks = 0;

   // shadow of the register file
   he_pkg::he_logn_t sh_logn;
   logic [31:0]      sh_a1;
   logic [31:0]      sh_wb1;
   logic [31:0]      sh_a2;
   logic [31:0]      sh_wb2;
   logic             sh_start;
   logic             job_active;

   logic                  exp_resp_v;
   he_pkg::he_host_resp_s exp_resp;

   // memory commands still to come, oldest first
   he_pkg::he_mem_cmd_s exp_cmd_q[$];
   int unsigned         exp_kind_q[$];

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // memory contents, every address bit takes part
   function automatic logic [`HE_COEF_W-1:0] mem_word(input logic [`HE_ADDR_W-1:0] addr);
      logic [31:0] x;
      x = SEED ^ addr[31:0] ^ {addr[`HE_ADDR_W-1:32], 24'h0};
      x = xorshift32(xorshift32(x));
      return x[`HE_COEF_W-1:0];
   endfunction

   function automatic int unsigned bitrev(input int unsigned j, input int unsigned logn);
      int unsigned r;
      r = 0;
      for (int i = 0; i < logn; i++)
         r = (r << 1) | ((j >> i) & 1);
      return r;
   endfunction

   // slot j of a round holds the coefficient loaded from a + 4 * bitrev(j)
   function automatic logic [`HE_DATA_W-1:0] ref_store_data(input logic [31:0] a,
                                                            input int unsigned j,
                                                            input int unsigned logn);
      logic [`HE_ADDR_W-1:0] src;
      src = `HE_ADDR_W'(a) + `HE_ADDR_W'(4 * bitrev(j, logn));
      return `HE_DATA_W'(mem_word(src));
   endfunction

   function automatic logic [`HE_DATA_W-1:0] csr_read_value(input logic [7:0] idx);
      case (idx)
         `HE_CSR_LOGN:   return `HE_DATA_W'(sh_logn);
         `HE_CSR_A1:     return `HE_DATA_W'(sh_a1);
         `HE_CSR_WB1:    return `HE_DATA_W'(sh_wb1);
         `HE_CSR_A2:     return `HE_DATA_W'(sh_a2);
         `HE_CSR_WB2:    return `HE_DATA_W'(sh_wb2);
         `HE_CSR_START:  return `HE_DATA_W'(sh_start);
         `HE_CSR_STATUS: return `HE_DATA_W'(job_active);
         default:        return '0;
      endcase
   endfunction

   task automatic push_expected(input he_pkg::he_msg_e msg,
                                input logic [`HE_ADDR_W-1:0] addr,
                                input logic [`HE_DATA_W-1:0] data,
                                input int unsigned kind);
      he_pkg::he_mem_cmd_s c;
      c.msg  = msg;
      c.addr = addr;
      c.data = data;
      exp_cmd_q.push_back(c);
      exp_kind_q.push_back(kind);
   endtask

   // two rounds of load and write-back, then interrupt set and clear
   task automatic queue_job();
      int unsigned n;
      logic [31:0] a;
      logic [31:0] wb;
      n = 1 << sh_logn;
      for (int r = 0; r < 2; r++)
      begin
         a  = (r == 0) ? sh_a1 : sh_a2;
         wb = (r == 0) ? sh_wb1 : sh_wb2;
         for (int k = 0; k < n; k++)
            push_expected(he_pkg::HE_MSG_RD, `HE_ADDR_W'(a) + `HE_ADDR_W'(4 * k), '0, KIND_RD);
         for (int j = 0; j < n; j++)
            push_expected(he_pkg::HE_MSG_WR, `HE_ADDR_W'(wb) + `HE_ADDR_W'(4 * j),
                          ref_store_data(a, j, sh_logn), KIND_WR);
      end
      push_expected(he_pkg::HE_MSG_WR, `HE_INTR_ADDR, '1, KIND_WR);
      push_expected(he_pkg::HE_MSG_WR, `HE_INTR_ADDR, '0, KIND_LAST);
   endtask

   //////////////////////////////////////////////////////////////////////
   // comparison
   //////////////////////////////////////////////////////////////////////

   task automatic check_field(input string name,
                              input logic [`HE_DATA_W-1:0] got,
                              input logic [`HE_DATA_W-1:0] want);
      if (got !== want)
      begin
         err_cnt++;
         $display("FAIL %s got %h exp %h at %0t", name, got, want, $time);
      end
   endtask

   task automatic check_host_resp();
      if (host_resp_v_i !== exp_resp_v)
      begin
         err_cnt++;
         $display("FAIL host_resp_v_o got %h exp %h at %0t", host_resp_v_i, exp_resp_v, $time);
      end
      else if (exp_resp_v)
      begin
         csr_checks++;
         check_field("host_resp_o.msg", `HE_DATA_W'(host_resp_i.msg), `HE_DATA_W'(exp_resp.msg));
         check_field("host_resp_o.addr", `HE_DATA_W'(host_resp_i.addr), `HE_DATA_W'(exp_resp.addr));
         check_field("host_resp_o.data", host_resp_i.data, exp_resp.data);
      end
   endtask

   // expectation for the next cycle, then the register shadow moves on
   task automatic predict_host_resp();
      logic       is_wr;
      logic       hit;
      logic [7:0] idx;
      logic       start_next;
      is_wr      = (host_cmd_i.msg == he_pkg::HE_MSG_WR);
      hit        = (host_cmd_i.addr[`HE_ADDR_W-1 -: `HE_HIO_W] == '0);
      idx        = host_cmd_i.addr[`HE_CSR_IDX_W-1:0];
      start_next = 1'b0;
      exp_resp_v = host_cmd_v_i && (hit || is_wr);
      if (host_cmd_v_i)
      begin
         exp_resp.msg  = host_cmd_i.msg;
         exp_resp.addr = host_cmd_i.addr;
         exp_resp.data = is_wr ? host_cmd_i.data : csr_read_value(idx);
         if (hit && is_wr)
         begin
            case (idx)
               `HE_CSR_LOGN: sh_logn = he_pkg::he_logn_t'(host_cmd_i.data);
               `HE_CSR_A1:   sh_a1   = host_cmd_i.data[31:0];
               `HE_CSR_WB1:  sh_wb1  = host_cmd_i.data[31:0];
               `HE_CSR_A2:   sh_a2   = host_cmd_i.data[31:0];
               `HE_CSR_WB2:  sh_wb2  = host_cmd_i.data[31:0];
               `HE_CSR_START:
               begin
                  start_next = host_cmd_i.data[0];
                  if (host_cmd_i.data[0])
                  begin
                     job_active = 1'b1;
                     queue_job();
                  end
               end
               default: ;
            endcase
         end
      end
      sh_start = start_next;
   endtask

   task automatic check_mem_cmd();
      he_pkg::he_mem_cmd_s want;
      int unsigned         kind;
      if (!mem_cmd_v_i)
         return;
      if (exp_cmd_q.size() == 0)
      begin
         err_cnt++;
         $display("unexpected memory command to address %h at %0t", mem_cmd_i.addr, $time);
         return;
      end
      want = exp_cmd_q.pop_front();
      kind = exp_kind_q.pop_front();
      mem_checks++;
      check_field("mem_cmd_o.msg", `HE_DATA_W'(mem_cmd_i.msg), `HE_DATA_W'(want.msg));
      check_field("mem_cmd_o.addr", `HE_DATA_W'(mem_cmd_i.addr), `HE_DATA_W'(want.addr));
      if (kind != KIND_RD)
         check_field("mem_cmd_o.data", mem_cmd_i.data, want.data);
      // status drops once the clear write has gone out
      if (kind == KIND_LAST)
         job_active = 1'b0;
   endtask

   task automatic check_drained();
      if (exp_cmd_q.size() != 0)
      begin
         err_cnt++;
         $display("%0d expected memory commands never appeared, first one to address %h",
                  exp_cmd_q.size(), exp_cmd_q[0].addr);
         exp_cmd_q.delete();
         exp_kind_q.delete();
      end
   endtask

   always @(posedge clk_i)
   begin : watch
      if (reset_i)
      begin
         exp_resp_v = 1'b0;
         sh_logn    = '0;
         sh_a1      = '0;
         sh_wb1     = '0;
         sh_a2      = '0;
         sh_wb2     = '0;
         sh_start   = 1'b0;
         job_active = 1'b0;
      end
      else
      begin
         check_host_resp();
         predict_host_resp();
         check_mem_cmd();
      end
   end

endmodule

`default_nettype wire

// File: tb_he_accel.sv
`timescale 1ns/1ns
`default_nettype none

`include "he_macros.svh"

module tb_he_accel;

   localparam logic [31:0] RNG_SEED = 32'h6d9c_6f57;

   // each job makes 4 * 2^logn transfers plus the set and clear writes
   localparam int JOB1_LOGN      = 3;
   localparam int JOB2_LOGN      = 5;
   localparam int MEM_CMDS       = 4 * (1 << JOB1_LOGN) + 2 + 4 * (1 << JOB2_LOGN) + 2;
   localparam int TIMEOUT_CYCLES = 20 * MEM_CMDS + 200;

   // device space whose low byte matches the a1 index
   localparam logic [`HE_ADDR_W-1:0] OUT_ADDR = {4'h1, 28'h000_0040, 8'(`HE_CSR_A1)};

   logic                  clk;
   logic                  reset;
   logic                  host_cmd_v;
   he_pkg::he_host_cmd_s  host_cmd;
   logic                  host_resp_v;
   he_pkg::he_host_resp_s host_resp;
   logic                  mem_cmd_v;
   he_pkg::he_mem_cmd_s   mem_cmd;
   logic                  mem_resp_v;
   logic [`HE_DATA_W-1:0] mem_resp_data;

   logic [`HE_ADDR_W-1:0] pend_addr[$];
   int unsigned           pend_wait[$];
   logic [31:0]           delay_rng;
   int unsigned           cycle_cnt = 0;

   tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) clk_gen_i (
      .clk_o   (clk),
      .reset_o (reset)
   );

   he_accel_top dut_i (
      .clk_i           (clk),
      .reset_i         (reset),
      .host_cmd_v_i    (host_cmd_v),
      .host_cmd_i      (host_cmd),
      .host_resp_v_o   (host_resp_v),
      .host_resp_o     (host_resp),
      .mem_cmd_v_o     (mem_cmd_v),
      .mem_cmd_o       (mem_cmd),
      .mem_resp_v_i    (mem_resp_v),
      .mem_resp_data_i (mem_resp_data)
   );

   tb_checker #(.SEED(RNG_SEED)) checker_i (
      .clk_i         (clk),
      .reset_i       (reset),
      .host_cmd_v_i  (host_cmd_v),
      .host_cmd_i    (host_cmd),
      .host_resp_v_i (host_resp_v),
      .host_resp_i   (host_resp),
      .mem_cmd_v_i   (mem_cmd_v),
      .mem_cmd_i     (mem_cmd)
   );

   //////////////////////////////////////////////////////////////////////
   // memory model that answers each command after 1 to 4 cycles
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      if (!reset && mem_cmd_v)
      begin
         delay_rng = checker_i.xorshift32(delay_rng);
         pend_addr.push_back(mem_cmd.addr);
         pend_wait.push_back(1 + delay_rng[1:0]);
      end
   end

   initial
   begin
      mem_resp_v    = 1'b0;
      mem_resp_data = '0;
      delay_rng     = RNG_SEED;
      forever
      begin
         @(negedge clk);
         mem_resp_v    = 1'b0;
         mem_resp_data = '0;
         // only the oldest command counts down
         if (pend_wait.size() != 0)
         begin
            pend_wait[0] = pend_wait[0] - 1;
            if (pend_wait[0] == 0)
            begin
               mem_resp_v    = 1'b1;
               mem_resp_data = `HE_DATA_W'(checker_i.mem_word(pend_addr[0]));
               void'(pend_wait.pop_front());
               void'(pend_addr.pop_front());
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // host tasks start and end on a falling edge
   //////////////////////////////////////////////////////////////////////

   function automatic logic [`HE_ADDR_W-1:0] csr_addr(input int idx);
      return `HE_ADDR_W'(idx);
   endfunction

   task automatic host_write(input logic [`HE_ADDR_W-1:0] addr,
                             input logic [`HE_DATA_W-1:0] data);
      host_cmd_v    = 1'b1;
      host_cmd.msg  = he_pkg::HE_MSG_WR;
      host_cmd.addr = addr;
      host_cmd.data = data;
      @(negedge clk);
      host_cmd_v    = 1'b0;
   endtask

   task automatic host_read(input logic [`HE_ADDR_W-1:0] addr,
                            output logic [`HE_DATA_W-1:0] data);
      host_cmd_v    = 1'b1;
      host_cmd.msg  = he_pkg::HE_MSG_RD;
      host_cmd.addr = addr;
      host_cmd.data = '0;
      @(negedge clk);
      host_cmd_v    = 1'b0;
      data          = host_resp.data;
   endtask

   task automatic write_config(input int logn, input logic [31:0] a1, input logic [31:0] wb1,
                               input logic [31:0] a2, input logic [31:0] wb2);
      host_write(csr_addr(`HE_CSR_LOGN), `HE_DATA_W'(logn));
      host_write(csr_addr(`HE_CSR_A1), `HE_DATA_W'(a1));
      host_write(csr_addr(`HE_CSR_WB1), `HE_DATA_W'(wb1));
      host_write(csr_addr(`HE_CSR_A2), `HE_DATA_W'(a2));
      host_write(csr_addr(`HE_CSR_WB2), `HE_DATA_W'(wb2));
   endtask

   task automatic read_config();
      logic [`HE_DATA_W-1:0] rd;
      for (int idx = `HE_CSR_LOGN; idx <= `HE_CSR_WB2; idx++)
         host_read(csr_addr(idx), rd);
   endtask

   task automatic wait_job_done();
      logic [`HE_DATA_W-1:0] status;
      status = '1;
      while (status != '0)
      begin
         repeat (8) @(negedge clk);
         host_read(csr_addr(`HE_CSR_STATUS), status);
      end
   endtask

   task automatic run_job();
      logic [`HE_DATA_W-1:0] rd;
      // a late answer to the last clear write must not meet the first load
      while (pend_wait.size() != 0)
         @(negedge clk);
      host_write(csr_addr(`HE_CSR_START), 64'h1);
      host_read(csr_addr(`HE_CSR_STATUS), rd);
      wait_job_done();
      checker_i.check_drained();
   endtask

   task automatic report_counts();
      $display("checks: %0d csr responses, %0d memory commands; errors: %0d",
               checker_i.csr_checks, checker_i.mem_checks, checker_i.err_cnt);
   endtask

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run still going after %0d cycles", cycle_cnt);
         report_counts();
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial
   begin : stimulus
      logic [`HE_DATA_W-1:0] rd;
      host_cmd_v = 1'b0;
      host_cmd   = '0;
      @(negedge clk);
      while (reset)
         @(negedge clk);

      // register round trip plus start and status at rest
      write_config(JOB1_LOGN, 32'h0001_0000, 32'h0002_0000, 32'h0003_0400, 32'h0004_0800);
      read_config();
      host_read(csr_addr(`HE_CSR_START), rd);
      host_read(csr_addr(`HE_CSR_STATUS), rd);

      // device space outside the csr block
      host_write(OUT_ADDR, 64'h0000_5a5a_1234_abcd);
      host_read(OUT_ADDR, rd);
      repeat (2) @(negedge clk);

      run_job();

      write_config(JOB2_LOGN, 32'h0010_0100, 32'h0020_0200, 32'h0035_0000, 32'h0041_0c00);
      read_config();
      run_job();

      repeat (10) @(negedge clk);
      checker_i.check_drained();
      report_counts();
      if (checker_i.err_cnt == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
he_pkg.sv
he_csr_regs.sv
he_sequencer.sv
he_mem_master.sv
he_coef_banks.sv
he_accel_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_he_accel.sv

// File: Bender.yml
package:
  name: he_accel

sources:
  - include_dirs:
      - .
    files:
      - he_pkg.sv
      - he_csr_regs.sv
      - he_sequencer.sv
      - he_mem_master.sv
      - he_coef_banks.sv
      - he_accel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_he_accel.sv
